//--- verilog/cp0Pkg.sv
package cp0Pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regNum_t;
    typedef logic [2:0]  regSel_t;

    localparam regNum_t INDEX_NUM    = 5'd0;
    localparam regNum_t BADVADDR_NUM = 5'd8;
    localparam regNum_t COUNT_NUM    = 5'd9;
    localparam regNum_t ENTRYHI_NUM  = 5'd10;
    localparam regNum_t COMPARE_NUM  = 5'd11;
    localparam regNum_t STATUS_NUM   = 5'd12;
    localparam regNum_t CAUSE_NUM    = 5'd13;
    localparam regNum_t EPC_NUM      = 5'd14;
    localparam regNum_t PRID_NUM     = 5'd15;   // Sel 1 is EBase
    localparam regNum_t CONFIG_NUM   = 5'd16;   // Sel 1 is Config1
    localparam regNum_t ERROREPC_NUM = 5'd30;

    localparam word_t STATUS_MASK   = 32'h1040_FF07;   // CU0, BEV, IM, ERL, EXL, IE
    localparam word_t CAUSE_MASK    = 32'h0000_0300;   // IP1..IP0 only
    localparam word_t EPC_MASK      = 32'hFFFF_FFFF;
    localparam word_t EBASE_MASK    = 32'h3FFF_F000;
    localparam word_t COMPARE_MASK  = 32'hFFFF_FFFF;
    localparam word_t COUNT_MASK    = 32'hFFFF_FFFF;
    localparam word_t ERROREPC_MASK = 32'hFFFF_FFFF;
    localparam word_t INDEX_MASK    = 32'h0000_001F;
    localparam word_t ENTRYHI_MASK  = 32'hFFFF_E0FF;   // VPN2 and ASID

    localparam word_t STATUS_RESET  = 32'h1040_0004;
    localparam word_t PRID_VALUE    = 32'h00FF_0001;
    localparam word_t EBASE_RESET   = 32'h8000_0000;
    localparam word_t CONFIG_VALUE  = 32'h8000_0003;   // Config1 present, kseg0 cached
    localparam word_t CONFIG1_VALUE = 32'h005B_2D80;   // 4-way 16B-line caches, no MMU

    localparam int STATUS_EXL = 1;
    localparam int STATUS_ERL = 2;
    localparam int STATUS_BEV = 22;
    localparam int CAUSE_BD   = 31;
    localparam int CAUSE_TI   = 30;
    localparam int CAUSE_IP7  = 15;

    typedef struct packed {
        logic    writeEn;
        regNum_t num;
        regSel_t sel;
        word_t   writeData;
    } moveReq_t;

    // ErrorEPC rides along so a return can pick its target
    typedef struct packed {
        word_t count;
        word_t status;
        word_t cause;
        word_t epc;
        word_t eBase;
        word_t errorEpc;
    } cp0Status_t;

endpackage

//--- verilog/excPkg.sv
package excPkg;

    typedef logic [4:0] excCode_t;

    localparam excCode_t EXC_INT  = 5'd0;
    localparam excCode_t EXC_ADEL = 5'd4;
    localparam excCode_t EXC_ADES = 5'd5;
    localparam excCode_t EXC_SYS  = 5'd8;
    localparam excCode_t EXC_BP   = 5'd9;
    localparam excCode_t EXC_RI   = 5'd10;
    localparam excCode_t EXC_OV   = 5'd12;

    typedef enum logic {
        KIND_EXCEPTION,
        KIND_RETURN
    } excKind_t;

    typedef struct packed {
        excKind_t      kind;
        excCode_t      code;
        cp0Pkg::word_t pc;
        cp0Pkg::word_t badVAddr;
        logic          badValid;
        logic          inDelaySlot;
    } excReq_t;

    typedef struct packed {
        logic          apply;
        logic          isReturn;
        excCode_t      code;
        logic          epcWrite;   // Also gates Cause.BD
        cp0Pkg::word_t epc;
        logic          bd;
        logic          badValid;
        cp0Pkg::word_t badVAddr;
    } excUpdate_t;

    localparam cp0Pkg::word_t VECTOR_OFFSET = 32'h0000_0180;
    localparam cp0Pkg::word_t BOOT_VECTOR   = 32'hBFC0_0380;

endpackage

//--- verilog/cp0RegFile.sv
`timescale 1ns/10ps

module cp0RegFile (
    input  logic               clk,
    input  logic               rst,
    input  cp0Pkg::moveReq_t   move,
    input  excPkg::excUpdate_t update,
    output cp0Pkg::word_t      readData,
    output cp0Pkg::cp0Status_t snapshot
);

    import cp0Pkg::*;

    word_t index;
    word_t entryHi;
    word_t count;
    word_t compare;
    word_t status;
    word_t cause;
    word_t epc;
    word_t eBase;
    word_t badVAddr;
    word_t errorEpc;

    word_t statusNext;
    word_t causeNext;

    logic  divClk;
    logic  timerArmed;
    logic  selZero;
    logic  excEntry;

    logic  wrIndex;
    logic  wrEntryHi;
    logic  wrCount;
    logic  wrCompare;
    logic  wrStatus;
    logic  wrCause;
    logic  wrEpc;
    logic  wrEBase;
    logic  wrErrorEpc;

    function automatic word_t merge(input word_t old, input word_t mask);
        return (old & ~mask) | (move.writeData & mask);
    endfunction

    assign selZero  = (move.sel == 3'd0);
    assign excEntry = update.apply && !update.isReturn;

    assign wrIndex    = move.writeEn && selZero && (move.num == INDEX_NUM);
    assign wrEntryHi  = move.writeEn && selZero && (move.num == ENTRYHI_NUM);
    assign wrCount    = move.writeEn && selZero && (move.num == COUNT_NUM);
    assign wrCompare  = move.writeEn && selZero && (move.num == COMPARE_NUM);
    assign wrStatus   = move.writeEn && selZero && (move.num == STATUS_NUM);
    assign wrCause    = move.writeEn && selZero && (move.num == CAUSE_NUM);
    assign wrEpc      = move.writeEn && selZero && (move.num == EPC_NUM);
    assign wrEBase    = move.writeEn && (move.sel == 3'd1) && (move.num == PRID_NUM);
    assign wrErrorEpc = move.writeEn && selZero && (move.num == ERROREPC_NUM);

    always_comb begin
        statusNext = status;
        if (update.apply) begin
            if (!update.isReturn) begin
                statusNext[STATUS_EXL] = 1'b1;
            end else if (status[STATUS_ERL]) begin
                statusNext[STATUS_ERL] = 1'b0;
            end else begin
                statusNext[STATUS_EXL] = 1'b0;
            end
        end else if (wrStatus) begin
            statusNext = merge(status, STATUS_MASK);
        end
    end

    always_comb begin
        causeNext = cause;
        if (excEntry) begin
            causeNext[6:2] = update.code;   // ExcCode
            if (update.epcWrite) begin
                causeNext[CAUSE_BD] = update.bd;
            end
        end else if (wrCause) begin
            causeNext = merge(cause, CAUSE_MASK);
        end
        if (wrCompare) begin
            causeNext[CAUSE_TI]  = 1'b0;
            causeNext[CAUSE_IP7] = 1'b0;
        end else if (timerArmed && (count == compare)) begin
            causeNext[CAUSE_TI]  = 1'b1;
            causeNext[CAUSE_IP7] = 1'b1;
        end
    end

    // Timer match stays off until Compare has been written once
    always_ff @(posedge clk) begin
        if (rst) begin
            divClk     <= 1'b0;
            timerArmed <= 1'b0;
            count      <= '0;
            compare    <= '0;
            status     <= STATUS_RESET;
            cause      <= '0;
            eBase      <= EBASE_RESET;
        end else begin
            divClk <= ~divClk;
            status <= statusNext;
            cause  <= causeNext;
            if (wrCount) begin
                count <= merge(count, COUNT_MASK);
            end else if (divClk) begin
                count <= count + 32'd1;   // Every second cycle
            end
            if (wrCompare) begin
                compare    <= merge(compare, COMPARE_MASK);
                timerArmed <= 1'b1;
            end
            if (wrEBase) begin
                eBase <= merge(eBase, EBASE_MASK);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrIndex) begin
            index <= merge(index, INDEX_MASK);
        end
        if (wrEntryHi) begin
            entryHi <= merge(entryHi, ENTRYHI_MASK);
        end
        if (wrErrorEpc) begin
            errorEpc <= merge(errorEpc, ERROREPC_MASK);
        end
        if (update.apply && update.epcWrite) begin
            epc <= update.epc;
        end else if (wrEpc) begin
            epc <= merge(epc, EPC_MASK);
        end
        if (update.apply && update.badValid) begin
            badVAddr <= update.badVAddr;
        end
    end

    always_comb begin
        readData = '0;
        if (selZero) begin
            case (move.num)
                INDEX_NUM:    readData = index;
                BADVADDR_NUM: readData = badVAddr;
                COUNT_NUM:    readData = count;
                ENTRYHI_NUM:  readData = entryHi;
                COMPARE_NUM:  readData = compare;
                STATUS_NUM:   readData = status;
                CAUSE_NUM:    readData = cause;
                EPC_NUM:      readData = epc;
                PRID_NUM:     readData = PRID_VALUE;
                CONFIG_NUM:   readData = CONFIG_VALUE;
                ERROREPC_NUM: readData = errorEpc;
                default:      readData = '0;
            endcase
        end else if (move.sel == 3'd1) begin
            case (move.num)
                PRID_NUM:   readData = eBase;
                CONFIG_NUM: readData = CONFIG1_VALUE;
                default:    readData = '0;
            endcase
        end
    end

    assign snapshot.count    = count;
    assign snapshot.status   = status;
    assign snapshot.cause    = cause;
    assign snapshot.epc      = epc;
    assign snapshot.eBase    = eBase;
    assign snapshot.errorEpc = errorEpc;

    returnNeedsLevel: assert property (@(posedge clk) disable iff (rst)
        update.apply && update.isReturn |-> status[STATUS_EXL] || status[STATUS_ERL])
        else $error("return applied with neither EXL nor ERL set");

endmodule

//--- verilog/exceptionUnit.sv
`timescale 1ns/10ps

module exceptionUnit (
    input  logic               clk,
    input  logic               rst,
    input  logic               excValid,
    input  logic               redirectReady,
    input  excPkg::excReq_t    excReq,
    input  cp0Pkg::cp0Status_t snapshot,
    output logic               excReady,
    output logic               redirectValid,
    output cp0Pkg::word_t      redirectPc,
    output excPkg::excUpdate_t update
);

    import cp0Pkg::*;
    import excPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        COMMIT,
        REDIRECT
    } state_t;

    state_t     state;
    excUpdate_t pending;
    excUpdate_t nextUpdate;
    word_t      nextTarget;
    word_t      target;
    logic       isReturn;
    logic       accept;

    assign accept   = excValid && excReady;
    assign isReturn = (excReq.kind == KIND_RETURN);

    // Everything here is taken from the snapshot at the accepting edge
    always_comb begin
        nextUpdate          = '0;
        nextUpdate.isReturn = isReturn;
        nextUpdate.code     = excReq.code;
        nextUpdate.epcWrite = !isReturn && !snapshot.status[STATUS_EXL];   // Nested keeps EPC
        nextUpdate.epc      = excReq.inDelaySlot ? excReq.pc - 32'd4 : excReq.pc;
        nextUpdate.bd       = excReq.inDelaySlot;
        nextUpdate.badValid = !isReturn && excReq.badValid;
        nextUpdate.badVAddr = excReq.badVAddr;

        if (isReturn) begin
            nextTarget = snapshot.status[STATUS_ERL] ? snapshot.errorEpc : snapshot.epc;
        end else if (snapshot.status[STATUS_BEV]) begin
            nextTarget = BOOT_VECTOR;
        end else begin
            nextTarget = snapshot.eBase + VECTOR_OFFSET;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (excValid) begin
                        state <= COMMIT;
                    end
                end
                COMMIT: state <= REDIRECT;
                REDIRECT: begin
                    if (redirectReady) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pending <= nextUpdate;
            target  <= nextTarget;
        end
    end

    assign excReady      = (state == IDLE);
    assign redirectValid = (state == REDIRECT);
    assign redirectPc    = target;

    always_comb begin
        update       = pending;
        update.apply = (state == COMMIT);   // One cycle per request
    end

    redirectHold: assert property (@(posedge clk) disable iff (rst)
        redirectValid && !redirectReady |=> redirectValid && $stable(redirectPc))
        else $error("redirect dropped or changed before it was taken");

    applyAfterAccept: assert property (@(posedge clk) disable iff (rst)
        update.apply |-> $past(accept))
        else $error("register update without an accepted request");

endmodule

//--- verilog/cp0Top.sv
`timescale 1ns/10ps

module cp0Top (
    input  logic               clk,
    input  logic               rst,
    input  cp0Pkg::moveReq_t   move,
    input  logic               excValid,
    input  logic               redirectReady,
    input  excPkg::excReq_t    excReq,
    output cp0Pkg::word_t      readData,
    output logic               excReady,
    output logic               redirectValid,
    output cp0Pkg::word_t      redirectPc,
    output cp0Pkg::cp0Status_t status
);

    import excPkg::*;

    excUpdate_t update;

    exceptionUnit u_exceptionUnit (
        .clk           (clk),
        .rst           (rst),
        .excValid      (excValid),
        .redirectReady (redirectReady),
        .excReq        (excReq),
        .snapshot      (status),
        .excReady      (excReady),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .update        (update)
    );

    // Status snapshot also feeds the pipeline
    cp0RegFile u_cp0RegFile (
        .clk      (clk),
        .rst      (rst),
        .move     (move),
        .update   (update),
        .readData (readData),
        .snapshot (status)
    );

endmodule

//--- bench/cp0Checker.sv
`timescale 1ns/10ps

module cp0Checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               excValid,
    input  logic               excReady,
    input  logic               redirectValid,
    input  logic               redirectReady,
    input  cp0Pkg::word_t      redirectPc,
    input  cp0Pkg::word_t      readData,
    input  cp0Pkg::cp0Status_t status,
    input  logic               checkRead,
    input  cp0Pkg::word_t      expRead,
    input  cp0Pkg::cp0Status_t expStatus,
    input  cp0Pkg::word_t      expPc,
    output int                 checks,
    output int                 mismatches,
    output int                 stalls
);

    import cp0Pkg::*;

    localparam int STUCK_LIMIT = 40;

    int    sinceAccept;
    int    lowCycles;
    logic  resetChecked;
    logic  wasStalled;
    word_t heldPc;

    task automatic mismatch(input string msg);
        mismatches++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    // Mid-cycle sampling, the bench only drives on the rising edge
    always @(negedge clk) begin
        if (rst) begin
            sinceAccept  = 0;
            lowCycles    = 0;
            resetChecked = 1'b0;
            wasStalled   = 1'b0;
        end else begin
            if (!resetChecked) begin
                checks++;
                if (excReady !== 1'b1 || redirectValid !== 1'b0) begin
                    mismatch($sformatf("after reset excReady=%b redirectValid=%b",
                        excReady, redirectValid));
                end
                resetChecked = 1'b1;
            end
            if (checkRead) begin
                checks++;
                if (readData !== expRead) begin
                    mismatch($sformatf("read returned %h, expected %h", readData, expRead));
                end
                checks++;
                if (status !== expStatus) begin
                    mismatch($sformatf("status output %h, expected %h", status, expStatus));
                end
            end
            if (sinceAccept == 1) begin   // COMMIT cycle
                checks++;
                if (redirectValid !== 1'b0 || excReady !== 1'b0) begin
                    mismatch("redirectValid or excReady high in the cycle after acceptance");
                end
                sinceAccept = 2;
            end else if (sinceAccept == 2) begin
                checks++;
                if (redirectValid !== 1'b1) begin
                    mismatch("redirectValid not raised one cycle after acceptance");
                end else if (redirectPc !== expPc) begin
                    mismatch($sformatf("redirectPc %h, expected %h", redirectPc, expPc));
                end
                sinceAccept = 0;
            end
            if (excValid && excReady) begin
                sinceAccept = 1;   // Accepted at the next edge
            end
            if (wasStalled) begin
                checks++;
                if (redirectValid !== 1'b1 || redirectPc !== heldPc) begin
                    mismatch("redirect dropped or changed while redirectReady was low");
                end
            end
            if (redirectValid && excReady) begin
                mismatch("excReady high while a redirect is pending");
            end
            wasStalled = redirectValid && !redirectReady;
            heldPc     = redirectPc;
            lowCycles  = excReady ? 0 : lowCycles + 1;
            if (lowCycles == STUCK_LIMIT) begin
                stalls++;
                $display("At %0t excReady stayed low for %0d cycles, the handshake is stuck",
                    $time, STUCK_LIMIT);
            end
        end
    end

endmodule

//--- bench/cp0Tb.sv
`timescale 1ns/10ps

module cp0Tb;

    import cp0Pkg::*;
    import excPkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_EXC    = 8;
    localparam int WAIT_LIMIT = 50;
    localparam int NUM_OPS    = 7 + 2 * 14 * 2 + 24 + NUM_EXC * 12 + 12;

    logic       clk;
    logic       rst;
    moveReq_t   move;
    logic       excValid;
    logic       redirectReady;
    excReq_t    excReq;
    word_t      readData;
    logic       excReady;
    logic       redirectValid;
    word_t      redirectPc;
    cp0Status_t status;

    logic       checkRead;
    word_t      expRead;
    cp0Status_t expStatus;
    word_t      expPc;
    int         checks;
    int         mismatches;
    int         stalls;
    int         timeouts;
    word_t      seed;
    int         cyc;   // Edges since reset release

    word_t      mIndex;
    word_t      mEntryHi;
    word_t      mCount;
    int         mCountEdge;
    word_t      mCompare;
    word_t      mStatus;
    word_t      mCause;
    word_t      mEpc;
    word_t      mEBase;
    word_t      mBadVAddr;
    word_t      mErrorEpc;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    cp0Top u_cp0Top (
        .clk           (clk),
        .rst           (rst),
        .move          (move),
        .excValid      (excValid),
        .redirectReady (redirectReady),
        .excReq        (excReq),
        .readData      (readData),
        .excReady      (excReady),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .status        (status)
    );

    cp0Checker u_cp0Checker (
        .clk           (clk),
        .rst           (rst),
        .excValid      (excValid),
        .excReady      (excReady),
        .redirectValid (redirectValid),
        .redirectReady (redirectReady),
        .redirectPc    (redirectPc),
        .readData      (readData),
        .status        (status),
        .checkRead     (checkRead),
        .expRead       (expRead),
        .expStatus     (expStatus),
        .expPc         (expPc),
        .checks        (checks),
        .mismatches    (mismatches),
        .stalls        (stalls)
    );

    function automatic word_t nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t maskedWrite(input word_t old, input word_t mask, input word_t data);
        return (old & ~mask) | (data & mask);
    endfunction

    // Count steps at every even edge after the load
    function automatic word_t countAt(input word_t loaded, input int loadEdge, input int edgeNum);
        return loaded + word_t'(edgeNum / 2 - loadEdge / 2);
    endfunction

    function automatic word_t modelRead(input regNum_t num, input regSel_t sel, input int edgeNum);
        if (sel == 3'd1) begin
            return (num == PRID_NUM) ? mEBase : (num == CONFIG_NUM) ? CONFIG1_VALUE : '0;
        end else if (sel != 3'd0) begin
            return '0;
        end
        case (num)
            INDEX_NUM:    return mIndex;
            ENTRYHI_NUM:  return mEntryHi;
            COUNT_NUM:    return countAt(mCount, mCountEdge, edgeNum);
            COMPARE_NUM:  return mCompare;
            STATUS_NUM:   return mStatus;
            CAUSE_NUM:    return mCause;
            EPC_NUM:      return mEpc;
            BADVADDR_NUM: return mBadVAddr;
            ERROREPC_NUM: return mErrorEpc;
            PRID_NUM:     return PRID_VALUE;
            CONFIG_NUM:   return CONFIG_VALUE;
            default:      return '0;
        endcase
    endfunction

    function automatic cp0Status_t modelSnapshot(input int edgeNum);
        cp0Status_t s;
        s.count    = countAt(mCount, mCountEdge, edgeNum);
        s.status   = mStatus;
        s.cause    = mCause;
        s.epc      = mEpc;
        s.eBase    = mEBase;
        s.errorEpc = mErrorEpc;
        return s;
    endfunction

    function automatic word_t targetFor(input excReq_t req);
        if (req.kind == KIND_RETURN) begin
            return mStatus[STATUS_ERL] ? mErrorEpc : mEpc;
        end
        return mStatus[STATUS_BEV] ? BOOT_VECTOR : mEBase + VECTOR_OFFSET;
    endfunction

    function automatic logic [7:0] accessAt(input int i);
        case (i)
            0:       return {INDEX_NUM, 3'd0};
            1:       return {ENTRYHI_NUM, 3'd0};
            2:       return {COUNT_NUM, 3'd0};
            3:       return {COMPARE_NUM, 3'd0};
            4:       return {STATUS_NUM, 3'd0};
            5:       return {CAUSE_NUM, 3'd0};
            6:       return {EPC_NUM, 3'd0};
            7:       return {PRID_NUM, 3'd1};   // EBase
            8:       return {ERROREPC_NUM, 3'd0};
            9:       return {PRID_NUM, 3'd0};
            10:      return {CONFIG_NUM, 3'd0};
            11:      return {CONFIG_NUM, 3'd1};
            12:      return {5'd3, 3'd0};   // Unimplemented
            default: return {STATUS_NUM, 3'd2};
        endcase
    endfunction

    function automatic excReq_t randomReq(input excKind_t kind, input logic inDelay);
        excReq_t r;
        word_t   pick;
        pick = nextRand();
        case (pick[30:28])
            3'd0:    r.code = EXC_INT;
            3'd1:    r.code = EXC_ADEL;
            3'd2:    r.code = EXC_ADES;
            3'd3:    r.code = EXC_SYS;
            3'd4:    r.code = EXC_BP;
            3'd5:    r.code = EXC_RI;
            default: r.code = EXC_OV;
        endcase
        r.kind        = kind;
        r.pc          = nextRand() & ~32'd3;
        r.badVAddr    = nextRand();
        r.badValid    = pick[31];
        r.inDelaySlot = inDelay;
        return r;
    endfunction

    task automatic modelRequest(input excReq_t req);
        if (req.kind == KIND_RETURN) begin
            if (mStatus[STATUS_ERL]) begin
                mStatus[STATUS_ERL] = 1'b0;
            end else begin
                mStatus[STATUS_EXL] = 1'b0;
            end
        end else begin
            if (!mStatus[STATUS_EXL]) begin
                mEpc             = req.inDelaySlot ? req.pc - 32'd4 : req.pc;
                mCause[CAUSE_BD] = req.inDelaySlot;
            end
            mCause[6:2] = req.code;
            if (req.badValid) begin
                mBadVAddr = req.badVAddr;
            end
            mStatus[STATUS_EXL] = 1'b1;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        cyc++;
    endtask

    task automatic drive(input moveReq_t m, input logic chk, input word_t exp);
        tick();
        move      <= m;
        checkRead <= chk;
        expRead   <= exp;
    endtask

    task automatic idle();
        drive('0, 1'b0, '0);
    endtask

    task automatic readCheck(input regNum_t num, input regSel_t sel);
        moveReq_t   m;
        cp0Status_t snap;
        m     = '0;
        m.num = num;
        m.sel = sel;
        snap  = modelSnapshot(cyc + 1);
        drive(m, 1'b1, modelRead(num, sel, cyc + 1));
        expStatus <= snap;
    endtask

    task automatic writeReg(input regNum_t num, input regSel_t sel, input word_t data);
        moveReq_t m;
        m.writeEn   = 1'b1;
        m.num       = num;
        m.sel       = sel;
        m.writeData = data;
        drive(m, 1'b0, '0);
        if (sel == 3'd1 && num == PRID_NUM) begin
            mEBase = maskedWrite(mEBase, EBASE_MASK, data);
        end else if (sel == 3'd0) begin
            case (num)
                INDEX_NUM:    mIndex = maskedWrite(mIndex, INDEX_MASK, data);
                ENTRYHI_NUM:  mEntryHi = maskedWrite(mEntryHi, ENTRYHI_MASK, data);
                STATUS_NUM:   mStatus = maskedWrite(mStatus, STATUS_MASK, data);
                CAUSE_NUM:    mCause = maskedWrite(mCause, CAUSE_MASK, data);
                EPC_NUM:      mEpc = maskedWrite(mEpc, EPC_MASK, data);
                ERROREPC_NUM: mErrorEpc = maskedWrite(mErrorEpc, ERROREPC_MASK, data);
                COUNT_NUM: begin
                    mCount     = maskedWrite(countAt(mCount, mCountEdge, cyc), COUNT_MASK, data);
                    mCountEdge = cyc + 1;
                end
                COMPARE_NUM: begin
                    mCompare          = maskedWrite(mCompare, COMPARE_MASK, data);
                    mCause[CAUSE_TI]  = 1'b0;
                    mCause[CAUSE_IP7] = 1'b0;
                end
                default: ;
            endcase
        end
    endtask

    task automatic awaitSignal(input logic forRedirect, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!(forRedirect ? redirectValid : excReady) && n < WAIT_LIMIT) begin
            tick();
            @(negedge clk);
            n++;
        end
        if (!(forRedirect ? redirectValid : excReady)) begin
            timeouts++;
            $display("Timed out at %0t waiting for %s", $time, what);
        end
    endtask

    task automatic sendRequest(input excReq_t req);
        word_t target;
        int    stall;
        target = targetFor(req);
        stall  = int'(nextRand() >> 29);
        idle();
        excValid      <= 1'b1;
        excReq        <= req;
        expPc         <= target;
        redirectReady <= 1'b0;
        awaitSignal(1'b0, "excReady");
        tick();   // Accepting edge
        excValid <= 1'b0;
        awaitSignal(1'b1, "redirectValid");
        repeat (stall) tick();
        tick();
        redirectReady <= 1'b1;
        tick();   // Redirect taken
        redirectReady <= 1'b0;
        modelRequest(req);
    endtask

    initial begin
        #(NUM_OPS * 20 * CLK_PERIOD);
        $display("Watchdog expired at %0t, the run did not finish in time", $time);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [7:0] acc;
        seed          = 32'hde2e;
        cyc           = 0;
        timeouts      = 0;
        rst           = 1'b1;
        move          = '0;
        excValid      = 1'b0;
        excReq        = '0;
        redirectReady = 1'b0;
        checkRead     = 1'b0;
        expRead       = '0;
        expStatus     = '0;
        expPc         = '0;
        mIndex        = 'x;   // No reset on these
        mEntryHi      = 'x;
        mEpc          = 'x;
        mBadVAddr     = 'x;
        mErrorEpc     = 'x;
        mCount        = '0;
        mCountEdge    = 0;
        mCompare      = '0;
        mStatus       = STATUS_RESET;
        mCause        = '0;
        mEBase        = EBASE_RESET;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        readCheck(STATUS_NUM, 3'd0);
        readCheck(PRID_NUM, 3'd0);
        readCheck(PRID_NUM, 3'd1);
        readCheck(CONFIG_NUM, 3'd0);
        readCheck(CONFIG_NUM, 3'd1);
        readCheck(CAUSE_NUM, 3'd0);
        readCheck(COMPARE_NUM, 3'd0);

        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 14; i++) begin
                acc = accessAt(i);
                writeReg(acc[7:3], acc[2:0], nextRand());
                readCheck(acc[7:3], acc[2:0]);
            end
        end

        writeReg(COUNT_NUM, 3'd0, nextRand() & 32'h7FFF_FFFF);
        repeat (7) idle();
        readCheck(COUNT_NUM, 3'd0);
        repeat (4) idle();
        readCheck(COUNT_NUM, 3'd0);
        writeReg(COMPARE_NUM, 3'd0, countAt(mCount, mCountEdge, cyc + 2) + 32'd3);
        repeat (12) idle();
        mCause[CAUSE_TI]  = 1'b1;   // Match has passed by now
        mCause[CAUSE_IP7] = 1'b1;
        readCheck(CAUSE_NUM, 3'd0);
        writeReg(COMPARE_NUM, 3'd0, countAt(mCount, mCountEdge, cyc) + 32'h4000_0000);
        readCheck(CAUSE_NUM, 3'd0);

        for (int i = 0; i < NUM_EXC; i++) begin
            writeReg(PRID_NUM, 3'd1, nextRand());
            writeReg(STATUS_NUM, 3'd0, i[0] ? 32'h1040_0000 : 32'h1000_0000);
            sendRequest(randomReq(KIND_EXCEPTION, i[1]));
            readCheck(EPC_NUM, 3'd0);
            readCheck(CAUSE_NUM, 3'd0);
            readCheck(BADVADDR_NUM, 3'd0);
            readCheck(STATUS_NUM, 3'd0);
            sendRequest(randomReq(KIND_EXCEPTION, !i[1]));   // Nested, EPC must hold
            readCheck(EPC_NUM, 3'd0);
            readCheck(CAUSE_NUM, 3'd0);
            sendRequest(randomReq(KIND_RETURN, 1'b0));
            readCheck(STATUS_NUM, 3'd0);
        end

        for (int i = 0; i < 2; i++) begin
            writeReg(ERROREPC_NUM, 3'd0, nextRand() & ~32'd3);
            writeReg(STATUS_NUM, 3'd0, i[0] ? 32'h1000_0006 : 32'h1000_0004);
            sendRequest(randomReq(KIND_RETURN, 1'b0));
            readCheck(STATUS_NUM, 3'd0);
            if (i == 1) begin
                sendRequest(randomReq(KIND_RETURN, 1'b0));   // EXL left over
                readCheck(STATUS_NUM, 3'd0);
            end
        end

        idle();
        idle();
        tick();
        $display("Checks %0d, mismatches %0d, stuck handshakes %0d, timeouts %0d",
            checks, mismatches, stalls, timeouts);
        if (mismatches + stalls + timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
verilog/cp0Pkg.sv
verilog/excPkg.sv
verilog/cp0RegFile.sv
verilog/exceptionUnit.sv
verilog/cp0Top.sv
bench/cp0Checker.sv
bench/cp0Tb.sv
